//--- design/cache_pkg.sv
/* widths, register map and bundle types shared by every cache block
   the other design files refer to these through cache_pkg:: names */
package cache_pkg;

   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 10;                // word address
   localparam int INDEX_W    = 4;                 // 16 one-word lines
   localparam int TAG_W      = ADDR_W - INDEX_W;
   localparam int WTB_DEPTH  = 4;
   localparam int CSR_ADDR_W = 4;

   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [ADDR_W-1:0]     addr_t;         // {tag, index}
   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [INDEX_W-1:0]    index_t;
   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   // register map, word addresses
   localparam csr_addr_t CSR_HIT        = 4'd0;   // read hits + write hits
   localparam csr_addr_t CSR_MISS       = 4'd1;
   localparam csr_addr_t CSR_READ_HIT   = 4'd2;
   localparam csr_addr_t CSR_READ_MISS  = 4'd3;
   localparam csr_addr_t CSR_WRITE_HIT  = 4'd4;
   localparam csr_addr_t CSR_WRITE_MISS = 4'd5;
   localparam csr_addr_t CSR_WTB_EMPTY  = 4'd6;
   localparam csr_addr_t CSR_WTB_FULL   = 4'd7;
   localparam csr_addr_t CSR_VERSION    = 4'd8;
   localparam csr_addr_t CSR_RST_CNTRS  = 4'd10;  // write-only command
   localparam csr_addr_t CSR_INVALIDATE = 4'd11;  // write-only command

   localparam data_t CACHE_VERSION = 32'h0001_0200;

   typedef struct packed {
      logic  write;
      addr_t addr;
      data_t wdata;
   } cache_req_t;

   typedef struct packed {
      logic      write;
      csr_addr_t addr;
   } csr_req_t;

   typedef struct packed {
      addr_t addr;
      data_t data;
   } mem_wr_t;

   // one-cycle pulses, at most one set per cycle
   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } cache_event_t;

   typedef enum logic [1:0] {
      CORE_IDLE,
      CORE_MEM_REQ,
      CORE_MEM_WAIT,
      CORE_REFILL
   } core_state_e;

endpackage

//--- design/cache_line_store.sv
/* valid, tag and data arrays of the direct-mapped cache
   lookup is combinational, fill/update/invalidate land on the clock edge */
`timescale 1ns/1ps

module cache_line_store (
   input  logic             clk_i,
   input  logic             arst_i,
   input  cache_pkg::addr_t lookup_addr_i,
   output logic             lookup_hit_o,
   output cache_pkg::data_t lookup_data_o,
   input  logic             fill_i,
   input  logic             update_i,
   input  cache_pkg::addr_t line_addr_i,
   input  cache_pkg::data_t line_data_i,
   input  logic             invalidate_i
);

   logic [2**cache_pkg::INDEX_W-1:0] valid_q;
   cache_pkg::tag_t                  tag_mem  [2**cache_pkg::INDEX_W];
   cache_pkg::data_t                 data_mem [2**cache_pkg::INDEX_W];

   cache_pkg::index_t lookup_idx;
   cache_pkg::tag_t   lookup_tag;
   cache_pkg::index_t line_idx;
   cache_pkg::tag_t   line_tag;
   logic              line_hit;

   assign lookup_idx = lookup_addr_i[cache_pkg::INDEX_W-1:0];
   assign lookup_tag = lookup_addr_i[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W];
   assign line_idx   = line_addr_i[cache_pkg::INDEX_W-1:0];
   assign line_tag   = line_addr_i[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W];

   assign lookup_hit_o  = valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
   assign lookup_data_o = data_mem[lookup_idx];
   assign line_hit      = valid_q[line_idx] && (tag_mem[line_idx] == line_tag);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;  // flush beats a refill in the same cycle
      end else if (fill_i) begin
         valid_q[line_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         tag_mem[line_idx]  <= line_tag;
         data_mem[line_idx] <= line_data_i;
      end else if (update_i && line_hit) begin
         data_mem[line_idx] <= line_data_i;  // write hit, tag unchanged
      end
   end

   // refill and write-hit come from different core states
   a_fill_update_excl : assert property (
      @(posedge clk_i) disable iff (arst_i) !(fill_i && update_i))
      else $error("cache_line_store: fill and update in the same cycle");

endmodule

//--- design/cache_core.sv
/* access FSM of the cache: classifies each CPU request, refills a line on a
   read miss and forwards every write to the write-through buffer */
`timescale 1ns/1ps

module cache_core (
   input  logic                    clk_i,
   input  logic                    arst_i,
   input  logic                    req_valid_i,
   input  cache_pkg::cache_req_t   req_i,
   output logic                    req_ready_o,
   output logic                    rsp_valid_o,
   output cache_pkg::data_t        rsp_rdata_o,
   output logic                    mem_rd_valid_o,
   output cache_pkg::addr_t        mem_rd_addr_o,
   input  logic                    mem_rd_ready_i,
   input  logic                    mem_rd_rsp_valid_i,
   input  cache_pkg::data_t        mem_rd_data_i,
   output cache_pkg::addr_t        lookup_addr_o,
   input  logic                    lookup_hit_i,
   input  cache_pkg::data_t        lookup_data_i,
   output logic                    fill_o,
   output logic                    update_o,
   output cache_pkg::addr_t        line_addr_o,
   output cache_pkg::data_t        line_data_o,
   input  logic                    inval_busy_i,
   output logic                    push_valid_o,
   output cache_pkg::mem_wr_t      push_o,
   input  logic                    push_ready_i,
   output cache_pkg::cache_event_t event_o
);

   cache_pkg::core_state_e state_q, state_d;
   cache_pkg::addr_t       addr_q;       // miss address
   cache_pkg::data_t       data_q;       // refill word
   cache_pkg::data_t       rsp_rdata_q;
   logic                   rsp_valid_q;
   logic                   idle;
   logic                   xfer;
   logic                   refill;

   assign idle   = (state_q == cache_pkg::CORE_IDLE);
   assign refill = (state_q == cache_pkg::CORE_REFILL);

   // writes also need a free buffer slot
   assign req_ready_o = idle && !inval_busy_i && (!(req_valid_i && req_i.write) || push_ready_i);
   assign xfer        = req_valid_i && req_ready_o;

   assign lookup_addr_o  = req_i.addr;
   assign mem_rd_valid_o = (state_q == cache_pkg::CORE_MEM_REQ);
   assign mem_rd_addr_o  = addr_q;

   assign fill_o      = refill;
   assign update_o    = xfer && req_i.write && lookup_hit_i;
   assign line_addr_o = refill ? addr_q : req_i.addr;
   assign line_data_o = refill ? data_q : req_i.wdata;

   assign push_valid_o = xfer && req_i.write;

   assign rsp_valid_o = rsp_valid_q || refill;  // refill answers in its own cycle
   assign rsp_rdata_o = refill ? data_q : rsp_rdata_q;

   always_comb begin
      push_o.addr = req_i.addr;
      push_o.data = req_i.wdata;
      event_o.read_hit   = xfer && !req_i.write && lookup_hit_i;
      event_o.read_miss  = xfer && !req_i.write && !lookup_hit_i;
      event_o.write_hit  = xfer && req_i.write && lookup_hit_i;
      event_o.write_miss = xfer && req_i.write && !lookup_hit_i;
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         cache_pkg::CORE_IDLE:
            if (xfer && !req_i.write && !lookup_hit_i) state_d = cache_pkg::CORE_MEM_REQ;
         cache_pkg::CORE_MEM_REQ:
            if (mem_rd_ready_i) state_d = cache_pkg::CORE_MEM_WAIT;
         cache_pkg::CORE_MEM_WAIT:
            if (mem_rd_rsp_valid_i) state_d = cache_pkg::CORE_REFILL;
         default: state_d = cache_pkg::CORE_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q     <= cache_pkg::CORE_IDLE;
         rsp_valid_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         rsp_valid_q <= xfer && (req_i.write || lookup_hit_i);  // hits and write acks
      end
   end

   always_ff @(posedge clk_i) begin
      if (xfer) begin
         addr_q      <= req_i.addr;
         rsp_rdata_q <= req_i.write ? '0 : lookup_data_i;
      end
      if (state_q == cache_pkg::CORE_MEM_WAIT && mem_rd_rsp_valid_i) data_q <= mem_rd_data_i;
   end

   // requester keeps its request until it transfers
   a_req_stable : assert property (@(posedge clk_i) disable iff (arst_i)
      req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i))
      else $error("cache_core: request dropped or changed before it transferred");

endmodule

//--- design/wt_buffer.sv
/* write-through FIFO between the cache core and the memory write port
   the head entry is offered to memory whenever the buffer holds data */
`timescale 1ns/1ps

module wt_buffer (
   input  logic               clk_i,
   input  logic               arst_i,
   input  logic               push_valid_i,
   input  cache_pkg::mem_wr_t push_i,
   output logic               push_ready_o,
   output logic               mem_wr_valid_o,
   output cache_pkg::mem_wr_t mem_wr_o,
   input  logic               mem_wr_ready_i,
   output logic               empty_o,
   output logic               full_o
);

   cache_pkg::mem_wr_t                     fifo_mem [cache_pkg::WTB_DEPTH];
   logic [$clog2(cache_pkg::WTB_DEPTH)-1:0] wr_ptr, rd_ptr;
   logic [$clog2(cache_pkg::WTB_DEPTH):0]   count;
   logic                                   push;
   logic                                   pop;

   assign empty_o        = (count == 0);
   assign full_o         = (count == cache_pkg::WTB_DEPTH);
   assign push_ready_o   = !full_o;
   assign mem_wr_valid_o = !empty_o;
   assign mem_wr_o       = fifo_mem[rd_ptr];  // head of queue

   assign push = push_valid_i && push_ready_o;
   assign pop  = mem_wr_valid_o && mem_wr_ready_i;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;  // power-of-two depth, wraps
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) fifo_mem[wr_ptr] <= push_i;
   end

   // core must hold writes back through its own ready
   a_no_push_full : assert property (
      @(posedge clk_i) disable iff (arst_i) !(push_valid_i && full_o))
      else $error("wt_buffer: push while full");

endmodule

//--- design/cache_ctrl_regs.sv
/* register block of the cache: event counters, buffer status, version word
   and the reset-counters and invalidate commands, acked one cycle later */
`timescale 1ns/1ps

module cache_ctrl_regs (
   input  logic                    clk_i,
   input  logic                    arst_i,
   input  logic                    csr_valid_i,
   input  cache_pkg::csr_req_t     csr_req_i,
   output logic                    csr_ready_o,
   output cache_pkg::data_t        csr_rdata_o,
   input  cache_pkg::cache_event_t event_i,
   input  logic                    wtb_empty_i,
   input  logic                    wtb_full_i,
   output logic                    invalidate_o
);

   cache_pkg::data_t read_hit_cnt;
   cache_pkg::data_t read_miss_cnt;
   cache_pkg::data_t write_hit_cnt;
   cache_pkg::data_t write_miss_cnt;
   cache_pkg::data_t rdata_d;
   logic             rst_cntrs;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end else if (rst_cntrs) begin
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end else begin
         if (event_i.read_hit) read_hit_cnt <= read_hit_cnt + 1'b1;
         if (event_i.read_miss) read_miss_cnt <= read_miss_cnt + 1'b1;
         if (event_i.write_hit) write_hit_cnt <= write_hit_cnt + 1'b1;
         if (event_i.write_miss) write_miss_cnt <= write_miss_cnt + 1'b1;
      end
   end

   // totals are summed at read time rather than counted
   always_comb begin
      rdata_d = '0;
      if (csr_valid_i && !csr_req_i.write) begin
         case (csr_req_i.addr)
            cache_pkg::CSR_HIT:        rdata_d = read_hit_cnt + write_hit_cnt;
            cache_pkg::CSR_MISS:       rdata_d = read_miss_cnt + write_miss_cnt;
            cache_pkg::CSR_READ_HIT:   rdata_d = read_hit_cnt;
            cache_pkg::CSR_READ_MISS:  rdata_d = read_miss_cnt;
            cache_pkg::CSR_WRITE_HIT:  rdata_d = write_hit_cnt;
            cache_pkg::CSR_WRITE_MISS: rdata_d = write_miss_cnt;
            cache_pkg::CSR_WTB_EMPTY:  rdata_d = cache_pkg::data_t'(wtb_empty_i);
            cache_pkg::CSR_WTB_FULL:   rdata_d = cache_pkg::data_t'(wtb_full_i);
            cache_pkg::CSR_VERSION:    rdata_d = cache_pkg::CACHE_VERSION;
            default:                   rdata_d = '0;  // unmapped
         endcase
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         csr_ready_o  <= 1'b0;
         rst_cntrs    <= 1'b0;
         invalidate_o <= 1'b0;
      end else begin
         csr_ready_o  <= csr_valid_i;  // ack next cycle
         rst_cntrs    <= csr_valid_i && csr_req_i.write &&
                         (csr_req_i.addr == cache_pkg::CSR_RST_CNTRS);
         invalidate_o <= csr_valid_i && csr_req_i.write &&
                         (csr_req_i.addr == cache_pkg::CSR_INVALIDATE);
      end
   end

   always_ff @(posedge clk_i) begin
      csr_rdata_o <= rdata_d;
   end

   // both status flags come from the one buffer count
   a_wtb_flags_excl : assert property (
      @(posedge clk_i) disable iff (arst_i) !(wtb_empty_i && wtb_full_i))
      else $error("cache_ctrl_regs: write buffer flagged empty and full at once");

endmodule

//--- design/cache_top.sv
/* top level of the write-through cache, joining the access core, the line
   arrays, the write buffer and the register block to the outside ports */
`timescale 1ns/1ps

module cache_top (
   input  logic                  clk_i,
   input  logic                  arst_i,
   input  logic                  req_valid_i,
   input  cache_pkg::cache_req_t req_i,
   output logic                  req_ready_o,
   output logic                  rsp_valid_o,
   output cache_pkg::data_t      rsp_rdata_o,
   output logic                  mem_rd_valid_o,
   output cache_pkg::addr_t      mem_rd_addr_o,
   input  logic                  mem_rd_ready_i,
   input  logic                  mem_rd_rsp_valid_i,
   input  cache_pkg::data_t      mem_rd_data_i,
   output logic                  mem_wr_valid_o,
   output cache_pkg::mem_wr_t    mem_wr_o,
   input  logic                  mem_wr_ready_i,
   input  logic                  csr_valid_i,
   input  cache_pkg::csr_req_t   csr_req_i,
   output logic                  csr_ready_o,
   output cache_pkg::data_t      csr_rdata_o
);

   cache_pkg::addr_t       lookup_addr;
   logic                   lookup_hit;
   cache_pkg::data_t       lookup_data;
   logic                   fill;
   logic                   update;
   cache_pkg::addr_t       line_addr;
   cache_pkg::data_t       line_data;
   logic                   push_valid;
   cache_pkg::mem_wr_t     push;
   logic                   push_ready;
   cache_pkg::cache_event_t events;
   logic                   wtb_empty;
   logic                   wtb_full;
   logic                   invalidate;  // also stalls the core

   cache_core core (
      .clk_i, .arst_i,
      .req_valid_i, .req_i, .req_ready_o, .rsp_valid_o, .rsp_rdata_o,
      .mem_rd_valid_o, .mem_rd_addr_o, .mem_rd_ready_i, .mem_rd_rsp_valid_i, .mem_rd_data_i,
      .lookup_addr_o(lookup_addr), .lookup_hit_i(lookup_hit), .lookup_data_i(lookup_data),
      .fill_o(fill), .update_o(update), .line_addr_o(line_addr), .line_data_o(line_data),
      .inval_busy_i(invalidate),
      .push_valid_o(push_valid), .push_o(push), .push_ready_i(push_ready),
      .event_o(events)
   );

   cache_line_store lines (
      .clk_i, .arst_i,
      .lookup_addr_i(lookup_addr), .lookup_hit_o(lookup_hit), .lookup_data_o(lookup_data),
      .fill_i(fill), .update_i(update), .line_addr_i(line_addr), .line_data_i(line_data),
      .invalidate_i(invalidate)
   );

   wt_buffer wtb (
      .clk_i, .arst_i,
      .push_valid_i(push_valid), .push_i(push), .push_ready_o(push_ready),
      .mem_wr_valid_o, .mem_wr_o, .mem_wr_ready_i,
      .empty_o(wtb_empty), .full_o(wtb_full)
   );

   cache_ctrl_regs ctrl (
      .clk_i, .arst_i,
      .csr_valid_i, .csr_req_i, .csr_ready_o, .csr_rdata_o,
      .event_i(events), .wtb_empty_i(wtb_empty), .wtb_full_i(wtb_full),
      .invalidate_o(invalidate)
   );

endmodule

//--- verif/cache_tb.sv
/* directed testbench for cache_top, with a memory model behind both memory
   ports, a tag model of the cache and expected counters kept alongside */
`timescale 1ns/1ps

module cache_tb;

   // ~40 accesses and ~40 register reads, each well under 20 cycles
   localparam int WATCHDOG_NS = 20000;

   logic                    clk_i;
   logic                    arst_i;
   logic                    req_valid_i;
   cache_pkg::cache_req_t   req_i;
   logic                    req_ready_o;
   logic                    rsp_valid_o;
   cache_pkg::data_t        rsp_rdata_o;
   logic                    mem_rd_valid_o;
   cache_pkg::addr_t        mem_rd_addr_o;
   logic                    mem_rd_ready_i;
   logic                    mem_rd_rsp_valid_i;
   cache_pkg::data_t        mem_rd_data_i;
   logic                    mem_wr_valid_o;
   cache_pkg::mem_wr_t      mem_wr_o;
   logic                    mem_wr_ready_i;  // doubles as the write-accept flag
   logic                    csr_valid_i;
   cache_pkg::csr_req_t     csr_req_i;
   logic                    csr_ready_o;
   cache_pkg::data_t        csr_rdata_o;

   cache_pkg::data_t   mem [2**cache_pkg::ADDR_W];      // backing memory
   cache_pkg::data_t   exp_mem [2**cache_pkg::ADDR_W];  // memory as the CPU sees it
   cache_pkg::mem_wr_t exp_wr_q [$];                    // writes not yet at memory
   int                 mem_rd_count;
   cache_pkg::addr_t   last_rd_addr;
   logic [2**cache_pkg::INDEX_W-1:0] model_valid;
   cache_pkg::tag_t    model_tag [2**cache_pkg::INDEX_W];
   cache_pkg::data_t   exp_rh, exp_rm, exp_wh, exp_wm;

   cache_top UUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_data(cache_pkg::data_t got, cache_pkg::data_t exp, string name);
      if (got !== exp) begin
         $display("CHECK FAILED t=%0t %s: expected %h, got %h", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_addr(cache_pkg::addr_t got, cache_pkg::addr_t exp, string name);
      if (got !== exp) begin
         $display("CHECK FAILED t=%0t %s: expected %h, got %h", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_bit(logic got, logic exp, string name);
      if (got !== exp) begin
         $display("CHECK FAILED t=%0t %s: expected %b, got %b", $time, name, exp, got);
         abort_run();
      end
   endtask

   function automatic logic model_hit(cache_pkg::addr_t a);
      cache_pkg::index_t idx;
      idx = a[cache_pkg::INDEX_W-1:0];
      return model_valid[idx] && (model_tag[idx] == a[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W]);
   endfunction

   // read port: accepts at once, answers 1 to 3 cycles later
   initial begin : mem_read_model
      cache_pkg::addr_t rd_addr;
      void'($urandom(26));
      forever begin
         @(negedge clk_i);
         if (mem_rd_valid_o && mem_rd_ready_i) begin
            rd_addr = mem_rd_addr_o;
            last_rd_addr = rd_addr;
            mem_rd_count++;
            @(posedge clk_i);  // handshake edge
            repeat ($urandom_range(3, 1)) @(posedge clk_i);
            mem_rd_rsp_valid_i <= 1'b1;
            mem_rd_data_i      <= mem[rd_addr];
            @(posedge clk_i);
            mem_rd_rsp_valid_i <= 1'b0;
         end
      end
   end

   // write port: every accepted write must be the oldest outstanding one
   always @(negedge clk_i) begin : mem_write_model
      cache_pkg::mem_wr_t exp_wr;
      if (mem_wr_valid_o && mem_wr_ready_i) begin
         if (exp_wr_q.size() == 0) begin
            $display("memory write port fired at %0t with no CPU write outstanding", $time);
            abort_run();
         end else begin
            exp_wr = exp_wr_q.pop_front();
            check_addr(mem_wr_o.addr, exp_wr.addr, "mem_wr_o.addr");
            check_data(mem_wr_o.data, exp_wr.data, "mem_wr_o.data");
            mem[mem_wr_o.addr] = mem_wr_o.data;
         end
      end
   end

   initial begin
      #WATCHDOG_NS;
      $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
      abort_run();
   end

   task automatic drive_req(logic wr, cache_pkg::addr_t addr, cache_pkg::data_t wdata);
      @(posedge clk_i);
      req_valid_i   <= 1'b1;
      req_i.write   <= wr;
      req_i.addr    <= addr;
      req_i.wdata   <= wdata;
   endtask

   // waits for the transfer, updates the models and checks the response
   task automatic finish_req();
      cache_pkg::addr_t   a;
      cache_pkg::index_t  idx;
      cache_pkg::mem_wr_t wr_entry;
      cache_pkg::data_t   exp_rdata;
      logic               wr;
      logic               hit;
      int                 rd_before;
      @(negedge clk_i);
      while (!req_ready_o) @(negedge clk_i);
      a         = req_i.addr;
      wr        = req_i.write;
      idx       = a[cache_pkg::INDEX_W-1:0];
      hit       = model_hit(a);
      rd_before = mem_rd_count;
      @(posedge clk_i);  // transfer edge
      req_valid_i <= 1'b0;
      if (wr) begin
         wr_entry.addr = a;
         wr_entry.data = req_i.wdata;
         exp_wr_q.push_back(wr_entry);
         exp_mem[a] = req_i.wdata;
         if (hit) exp_wh = exp_wh + 1;
         else exp_wm = exp_wm + 1;  // no allocate
      end else if (hit) begin
         exp_rh = exp_rh + 1;
      end else begin
         exp_rm = exp_rm + 1;
         model_valid[idx] = 1'b1;
         model_tag[idx]   = a[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W];
      end
      @(negedge clk_i);
      if (wr || hit) check_bit(rsp_valid_o, 1'b1, "rsp_valid_o");  // one cycle latency
      else while (!rsp_valid_o) @(negedge clk_i);
      exp_rdata = wr ? 32'h0 : exp_mem[a];
      check_data(rsp_rdata_o, exp_rdata, "rsp_rdata_o");
      if (!wr && !hit) check_addr(last_rd_addr, a, "mem_rd_addr_o");
      if (mem_rd_count - rd_before != ((!wr && !hit) ? 1 : 0)) begin
         $display("wrong number of memory reads for access to %h at %0t", a, $time);
         abort_run();
      end
   endtask

   task automatic cpu_access(logic wr, cache_pkg::addr_t addr, cache_pkg::data_t wdata);
      drive_req(wr, addr, wdata);
      finish_req();
   endtask

   task automatic csr_access(logic wr, cache_pkg::csr_addr_t addr, output cache_pkg::data_t rdata);
      @(posedge clk_i);
      csr_valid_i    <= 1'b1;
      csr_req_i.write <= wr;
      csr_req_i.addr  <= addr;
      @(posedge clk_i);
      csr_valid_i <= 1'b0;
      @(negedge clk_i);
      check_bit(csr_ready_o, 1'b1, "csr_ready_o");
      rdata = csr_rdata_o;
   endtask

   task automatic csr_expect(cache_pkg::csr_addr_t addr, cache_pkg::data_t exp, string name);
      cache_pkg::data_t v;
      csr_access(1'b0, addr, v);
      check_data(v, exp, name);
   endtask

   task automatic csr_command(cache_pkg::csr_addr_t addr);
      cache_pkg::data_t unused;
      csr_access(1'b1, addr, unused);
   endtask

   task automatic check_counters();
      csr_expect(cache_pkg::CSR_READ_HIT, exp_rh, "READ_HIT");
      csr_expect(cache_pkg::CSR_READ_MISS, exp_rm, "READ_MISS");
      csr_expect(cache_pkg::CSR_WRITE_HIT, exp_wh, "WRITE_HIT");
      csr_expect(cache_pkg::CSR_WRITE_MISS, exp_wm, "WRITE_MISS");
      csr_expect(cache_pkg::CSR_HIT, exp_rh + exp_wh, "HIT");
      csr_expect(cache_pkg::CSR_MISS, exp_rm + exp_wm, "MISS");
   endtask

   task automatic wait_drain();
      while (exp_wr_q.size() != 0) @(posedge clk_i);
   endtask

   task automatic test_after_reset();
      @(negedge clk_i);
      check_bit(req_ready_o, 1'b1, "req_ready_o");
      check_bit(rsp_valid_o, 1'b0, "rsp_valid_o");
      check_bit(mem_rd_valid_o, 1'b0, "mem_rd_valid_o");
      check_bit(mem_wr_valid_o, 1'b0, "mem_wr_valid_o");
      check_bit(csr_ready_o, 1'b0, "csr_ready_o");
      csr_expect(cache_pkg::CSR_VERSION, cache_pkg::CACHE_VERSION, "VERSION");
      csr_expect(cache_pkg::CSR_WTB_EMPTY, 32'd1, "WTB_EMPTY");
      csr_expect(cache_pkg::CSR_WTB_FULL, 32'd0, "WTB_FULL");
      check_counters();
   endtask

   task automatic test_reads();
      cpu_access(1'b0, 10'h025, '0);  // cold miss
      cpu_access(1'b0, 10'h025, '0);
      cpu_access(1'b0, 10'h135, '0);  // same index, new tag
      cpu_access(1'b0, 10'h135, '0);
      cpu_access(1'b0, 10'h025, '0);
      check_counters();
   endtask

   task automatic test_write_through();
      cpu_access(1'b1, 10'h025, 32'hCAFE_0001);  // write hit
      cpu_access(1'b0, 10'h025, '0);
      cpu_access(1'b1, 10'h2F0, 32'hBEEF_0002);
      cpu_access(1'b1, 10'h001, 32'hDEAD_0003);
      cpu_access(1'b1, 10'h3FF, 32'h1234_5678);
      wait_drain();
      cpu_access(1'b0, 10'h2F0, '0);  // not allocated by the write
      check_counters();
   endtask

   task automatic test_invalidate();
      cpu_access(1'b0, 10'h040, '0);
      cpu_access(1'b0, 10'h041, '0);
      cpu_access(1'b0, 10'h025, '0);
      csr_command(cache_pkg::CSR_INVALIDATE);
      model_valid = '0;
      cpu_access(1'b0, 10'h040, '0);
      cpu_access(1'b0, 10'h041, '0);
      cpu_access(1'b0, 10'h025, '0);
      check_counters();
   endtask

   task automatic test_reset_counters();
      csr_command(cache_pkg::CSR_RST_CNTRS);
      exp_rh = '0;
      exp_rm = '0;
      exp_wh = '0;
      exp_wm = '0;
      check_counters();
      cpu_access(1'b0, 10'h041, '0);  // line survives the counter reset
      check_counters();
   endtask

   task automatic test_backpressure();
      wait_drain();
      @(posedge clk_i);
      mem_wr_ready_i <= 1'b0;
      for (int i = 0; i < 4; i++) begin
         cpu_access(1'b1, cache_pkg::addr_t'(10'h200 + i), 32'h7000_0000 + i);
      end
      drive_req(1'b1, 10'h204, 32'h7000_0004);
      csr_expect(cache_pkg::CSR_WTB_FULL, 32'd1, "WTB_FULL");
      repeat (2) begin
         @(negedge clk_i);
         check_bit(req_ready_o, 1'b0, "req_ready_o");
      end
      @(posedge clk_i);
      mem_wr_ready_i <= 1'b1;
      finish_req();
      wait_drain();
      csr_expect(cache_pkg::CSR_WTB_EMPTY, 32'd1, "WTB_EMPTY");
      check_counters();
   endtask

   initial begin
      arst_i             = 1'b1;
      req_valid_i        = 1'b0;
      req_i              = '0;
      mem_rd_ready_i     = 1'b1;
      mem_rd_rsp_valid_i = 1'b0;
      mem_rd_data_i      = '0;
      mem_wr_ready_i     = 1'b1;
      csr_valid_i        = 1'b0;
      csr_req_i          = '0;
      mem_rd_count       = 0;
      last_rd_addr       = '0;
      model_valid        = '0;
      exp_rh             = '0;
      exp_rm             = '0;
      exp_wh             = '0;
      exp_wm             = '0;
      for (int i = 0; i < 2**cache_pkg::ADDR_W; i++) begin
         mem[i]     = 32'h5A5A_0000 ^ i;
         exp_mem[i] = 32'h5A5A_0000 ^ i;
      end
      repeat (4) @(posedge clk_i);
      arst_i <= 1'b0;
      test_after_reset();
      test_reads();
      test_write_through();
      test_invalidate();
      test_reset_counters();
      test_backpressure();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- build.f
design/cache_pkg.sv
design/cache_line_store.sv
design/cache_core.sv
design/wt_buffer.sv
design/cache_ctrl_regs.sv
design/cache_top.sv
verif/cache_tb.sv
